//--- src/loader_pkg.sv
/*
 * Shared definitions for the PRG injection path.
 * Holds the RAM byte types, the PS/2 key event layout, the zero page
 * BASIC pointer table patched after a load and the key sequence that
 * types RUN. Modules refer to these by scoped names.
 */
`default_nettype none

package loader_pkg;

	typedef logic [15:0] ram_addr_t;
	typedef logic [7:0]  ram_data_t;

	// Key event as delivered by the host, toggle flips on every new event
	typedef struct packed {
		logic       toggle;
		logic       pressed;
		logic       extended;
		logic [7:0] code;
	} ps2_key_t;

	// ==================================================================
	// BASIC pointer patch
	// ==================================================================

	typedef enum logic [2:0] {TXT_LO, TXT_HI, ZERO, END_LO, END_HI} ptr_kind_e;

	typedef struct packed {
		logic [7:0] zp_addr;
		ptr_kind_e  kind;
	} ptr_entry_t;

	localparam int PTR_TABLE_LEN = 12;

	// TXT, SAVE_START, then VAR, ARY, STR and LOAD_END at the end address
	localparam ptr_entry_t PTR_TABLE [PTR_TABLE_LEN] = '{
		'{8'h2B, TXT_LO}, '{8'h2C, TXT_HI},
		'{8'hAC, ZERO},   '{8'hAD, ZERO},
		'{8'h2D, END_LO}, '{8'h2E, END_HI},
		'{8'h2F, END_LO}, '{8'h30, END_HI},
		'{8'h31, END_LO}, '{8'h32, END_HI},
		'{8'hAE, END_LO}, '{8'hAF, END_HI}
	};

	localparam ram_addr_t TXT_START = 16'h0801;

	// ==================================================================
	// RUN key sequence
	// ==================================================================

	localparam logic [7:0] KEY_LSHIFT = 8'h12;
	localparam logic [7:0] KEY_HOME   = 8'h6C;
	localparam logic [7:0] KEY_R      = 8'h2D;
	localparam logic [7:0] KEY_U      = 8'h3C;
	localparam logic [7:0] KEY_N      = 8'h31;
	localparam logic [7:0] KEY_RETURN = 8'h5A;

	typedef struct packed {
		logic [7:0] code;
		logic       pressed;
		logic       extended;
	} key_seq_entry_t;

	localparam int KEY_SEQ_LEN = 12;

	// Shift+HOME clears the screen before RUN is typed
	localparam key_seq_entry_t KEY_SEQ [KEY_SEQ_LEN] = '{
		'{KEY_LSHIFT, 1'b1, 1'b0}, '{KEY_HOME, 1'b1, 1'b1},
		'{KEY_HOME, 1'b0, 1'b1},   '{KEY_LSHIFT, 1'b0, 1'b0},
		'{KEY_R, 1'b1, 1'b0},      '{KEY_R, 1'b0, 1'b0},
		'{KEY_U, 1'b1, 1'b0},      '{KEY_U, 1'b0, 1'b0},
		'{KEY_N, 1'b1, 1'b0},      '{KEY_N, 1'b0, 1'b0},
		'{KEY_RETURN, 1'b1, 1'b0}, '{KEY_RETURN, 1'b0, 1'b0}
	};

endpackage

`default_nettype wire

//--- src/mem_req_if.sv
/*
 * One RAM write request, valid/ready handshake.
 * A transfer happens in a cycle with valid and ready both high; the
 * producer keeps addr and data stable while it waits for ready.
 */
`default_nettype none

interface mem_req_if;

	logic                  valid;
	logic                  ready;
	loader_pkg::ram_addr_t addr;
	loader_pkg::ram_data_t data;

	modport producer (
		output valid,
		output addr,
		output data,
		input  ready
	);

	modport consumer (
		input  valid,
		input  addr,
		input  data,
		output ready
	);

endinterface

`default_nettype wire

//--- src/prg_stream_parser.sv
/*
 * PRG download parser.
 * Bytes 0 and 1 of the stream give the load address; each later byte
 * becomes one RAM write request at the next address. dl_wait_o holds
 * the host off while a request is pending. load_done_o pulses once the
 * download ends, load_end_o gives the first address past the data.
 */
`default_nettype none

module prg_stream_parser (
	input  wire logic                   clk_sys,
	input  wire logic                   reset_n,
	input  wire logic                   dl_active_i,
	input  wire logic                   dl_wr_i,
	input  wire loader_pkg::ram_addr_t  dl_addr_i,
	input  wire loader_pkg::ram_data_t  dl_data_i,
	output logic                        dl_wait_o,
	output loader_pkg::ram_addr_t       load_end_o,
	output logic                        load_done_o,
	mem_req_if.producer                 req
);

	loader_pkg::ram_addr_t wr_addr;
	loader_pkg::ram_addr_t end_addr;
	loader_pkg::ram_data_t data_q;
	logic                  valid_q;
	logic                  hdr_seen;
	logic                  active_q;
	logic                  is_header;

	assign is_header = (dl_addr_i < 16'd2);

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			valid_q     <= 1'b0;
			hdr_seen    <= 1'b0;
			active_q    <= 1'b0;
			load_done_o <= 1'b0;
		end else begin
			active_q    <= dl_active_i;
			load_done_o <= active_q && !dl_active_i && hdr_seen;
			if (req.valid && req.ready)
				valid_q <= 1'b0;
			if (dl_wr_i && !is_header)
				valid_q <= 1'b1;
			// A download without header never reports completion
			if (active_q && !dl_active_i)
				hdr_seen <= 1'b0;
			else if (dl_wr_i && is_header)
				hdr_seen <= 1'b1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (req.valid && req.ready)
			wr_addr <= wr_addr + 16'd1;
		if (dl_wr_i) begin
			if (dl_addr_i == 16'd0) begin
				wr_addr[7:0]  <= dl_data_i;
				end_addr[7:0] <= dl_data_i;
			end else if (dl_addr_i == 16'd1) begin
				wr_addr[15:8]  <= dl_data_i;
				end_addr[15:8] <= dl_data_i;
			end else begin
				data_q   <= dl_data_i;
				end_addr <= end_addr + 16'd1;
			end
		end
	end

	assign req.valid  = valid_q;
	assign req.addr   = wr_addr;
	assign req.data   = data_q;
	assign dl_wait_o  = valid_q;
	assign load_end_o = end_addr;

	// Host must not send a byte while the previous one is still pending
	assert property (@(posedge clk_sys) disable iff (!reset_n)
		dl_wr_i |-> !dl_wait_o);

endmodule

`default_nettype wire

//--- src/basic_ptr_patcher.sv
/*
 * BASIC pointer patch after a PRG load.
 * On load_done_i it writes the zero page pointer bytes from the package
 * table, one request each, so BASIC sees the state a LOAD would leave.
 * patch_done_o pulses the cycle after the last write is taken.
 */
`default_nettype none

module basic_ptr_patcher (
	input  wire logic                   clk_sys,
	input  wire logic                   reset_n,
	input  wire loader_pkg::ram_addr_t  load_end_i,
	input  wire logic                   load_done_i,
	output logic                        patch_done_o,
	mem_req_if.producer                 req
);

	typedef enum logic [1:0] {IDLE, WRITE, DONE} state_e;

	localparam logic [3:0] LAST_IDX = 4'(loader_pkg::PTR_TABLE_LEN - 1);

	state_e                 state;
	logic [3:0]             idx;
	loader_pkg::ram_addr_t  end_addr;
	loader_pkg::ptr_entry_t entry;
	loader_pkg::ram_data_t  ptr_byte;

	assign entry = loader_pkg::PTR_TABLE[idx];

	always_comb begin
		case (entry.kind)
			loader_pkg::TXT_LO: ptr_byte = loader_pkg::TXT_START[7:0];
			loader_pkg::TXT_HI: ptr_byte = loader_pkg::TXT_START[15:8];
			loader_pkg::END_LO: ptr_byte = end_addr[7:0];
			loader_pkg::END_HI: ptr_byte = end_addr[15:8];
			default:            ptr_byte = 8'h00;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			state <= IDLE;
			idx   <= 4'd0;
		end else begin
			case (state)
				IDLE: begin
					if (load_done_i) begin
						state <= WRITE;
						idx   <= 4'd0;
					end
				end
				WRITE: begin
					if (req.ready) begin
						if (idx == LAST_IDX)
							state <= DONE;
						else
							idx <= idx + 4'd1;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// End address is latched only when a patch starts
	always_ff @(posedge clk_sys) begin
		if (state == IDLE && load_done_i)
			end_addr <= load_end_i;
	end

	assign req.valid    = (state == WRITE);
	assign req.addr     = {8'h00, entry.zp_addr};
	assign req.data     = ptr_byte;
	assign patch_done_o = (state == DONE);

endmodule

`default_nettype wire

//--- src/mem_slot_writer.sv
/*
 * RAM slot writer.
 * Takes one request at a time from the parser (first) or the pointer
 * patcher into a single entry buffer, and writes it to RAM during the
 * next slot the CPU leaves open, marked by the fall of io_cycle_i.
 */
`default_nettype none

module mem_slot_writer (
	input  wire logic             clk_sys,
	input  wire logic             reset_n,
	input  wire logic             io_cycle_i,
	mem_req_if.consumer           prg_req,
	mem_req_if.consumer           ptr_req,
	output logic                  mem_we_o,
	output loader_pkg::ram_addr_t mem_addr_o,
	output loader_pkg::ram_data_t mem_data_o
);

	logic                  full;
	logic                  io_q;
	logic                  we_q;
	logic                  slot_open;
	loader_pkg::ram_addr_t buf_addr;
	loader_pkg::ram_data_t buf_data;

	// CPU has just released the bus
	assign slot_open = io_q && !io_cycle_i;

	// Parser has fixed priority over the patcher
	assign prg_req.ready = !full;
	assign ptr_req.ready = !full && !prg_req.valid;

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			full <= 1'b0;
			io_q <= 1'b0;
			we_q <= 1'b0;
		end else begin
			io_q <= io_cycle_i;
			we_q <= slot_open && full;
			if (slot_open && full)
				full <= 1'b0;
			else if (!full && (prg_req.valid || ptr_req.valid))
				full <= 1'b1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (!full) begin
			if (prg_req.valid) begin
				buf_addr <= prg_req.addr;
				buf_data <= prg_req.data;
			end else if (ptr_req.valid) begin
				buf_addr <= ptr_req.addr;
				buf_data <= ptr_req.data;
			end
		end
	end

	// Buffer may refill during the write cycle; outputs still show the old entry
	assign mem_we_o   = we_q;
	assign mem_addr_o = buf_addr;
	assign mem_data_o = buf_data;

	// Writes only while the CPU stays off the bus
	assert property (@(posedge clk_sys) disable iff (!reset_n)
		mem_we_o |-> !io_cycle_i);

endmodule

`default_nettype wire

//--- src/autotype_keyseq.sv
/*
 * Keyboard stream mux with RUN autotype.
 * Live key events pass through unchanged. After patch_done_i the key
 * sequence from the package is played instead, each event held for
 * KEY_HOLD_CYCLES cycles, then passthrough resumes.
 */
`default_nettype none

module autotype_keyseq #(
	parameter logic [19:0] KEY_HOLD_CYCLES = 20'd640000
) (
	input  wire logic                  clk_sys,
	input  wire logic                  reset_n,
	input  wire logic                  patch_done_i,
	input  wire loader_pkg::ps2_key_t  ps2_key_i,
	output loader_pkg::ps2_key_t       ps2_key_o
);

	typedef enum logic {PASS, PLAY} state_e;

	localparam logic [3:0] SEQ_LAST = 4'(loader_pkg::KEY_SEQ_LEN - 1);

	state_e                     state;
	logic [3:0]                 seq_idx;
	logic [3:0]                 seq_next;
	logic [19:0]                hold_cnt;
	logic                       hold_done;
	logic                       load_key;
	loader_pkg::ps2_key_t       key_q;
	loader_pkg::key_seq_entry_t next_entry;

	// Index rests on the last entry in PASS, so the next one wraps to 0
	assign seq_next   = (seq_idx == SEQ_LAST) ? 4'd0 : seq_idx + 4'd1;
	assign next_entry = loader_pkg::KEY_SEQ[seq_next];
	assign hold_done  = (hold_cnt == KEY_HOLD_CYCLES - 20'd1);
	assign load_key   = (state == PASS && patch_done_i) ||
	                    (state == PLAY && hold_done && seq_idx != SEQ_LAST);

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			state    <= PASS;
			seq_idx  <= SEQ_LAST;
			hold_cnt <= 20'd0;
		end else begin
			case (state)
				PASS: begin
					if (patch_done_i) begin
						state    <= PLAY;
						seq_idx  <= seq_next;
						hold_cnt <= 20'd0;
					end
				end
				default: begin
					if (hold_done) begin
						hold_cnt <= 20'd0;
						if (seq_idx == SEQ_LAST)
							state <= PASS;
						else
							seq_idx <= seq_next;
					end else begin
						hold_cnt <= hold_cnt + 20'd1;
					end
				end
			endcase
		end
	end

	// Flip toggle against what the receiver saw last
	always_ff @(posedge clk_sys) begin
		if (load_key) begin
			key_q.toggle   <= ~ps2_key_o.toggle;
			key_q.pressed  <= next_entry.pressed;
			key_q.extended <= next_entry.extended;
			key_q.code     <= next_entry.code;
		end
	end

	assign ps2_key_o = (state == PLAY) ? key_q : ps2_key_i;

endmodule

`default_nettype wire

//--- src/prg_loader_top.sv
/*
 * PRG injection path, top level.
 * Wires the download parser, the BASIC pointer patcher, the RAM slot
 * writer and the RUN autotype. KEY_HOLD_CYCLES sets how long each
 * typed key event is held.
 */
`default_nettype none

module prg_loader_top #(
	parameter logic [19:0] KEY_HOLD_CYCLES = 20'd640000
) (
	input  wire logic                   clk_sys,
	input  wire logic                   reset_n,
	// Download side
	input  wire logic                   dl_active_i,
	input  wire logic                   dl_wr_i,
	input  wire loader_pkg::ram_addr_t  dl_addr_i,
	input  wire loader_pkg::ram_data_t  dl_data_i,
	output logic                        dl_wait_o,
	// Memory side
	input  wire logic                   io_cycle_i,
	output logic                        mem_we_o,
	output loader_pkg::ram_addr_t       mem_addr_o,
	output loader_pkg::ram_data_t       mem_data_o,
	// Keyboard
	input  wire loader_pkg::ps2_key_t   ps2_key_i,
	output loader_pkg::ps2_key_t        ps2_key_o
);

	loader_pkg::ram_addr_t load_end;
	logic                  load_done;
	logic                  patch_done;

	mem_req_if parse_req ();
	mem_req_if patch_req ();

	prg_stream_parser prg_stream_parser_i (
		.clk_sys     (clk_sys),
		.reset_n     (reset_n),
		.dl_active_i (dl_active_i),
		.dl_wr_i     (dl_wr_i),
		.dl_addr_i   (dl_addr_i),
		.dl_data_i   (dl_data_i),
		.dl_wait_o   (dl_wait_o),
		.load_end_o  (load_end),
		.load_done_o (load_done),
		.req         (parse_req.producer)
	);

	basic_ptr_patcher basic_ptr_patcher_i (
		.clk_sys      (clk_sys),
		.reset_n      (reset_n),
		.load_end_i   (load_end),
		.load_done_i  (load_done),
		.patch_done_o (patch_done),
		.req          (patch_req.producer)
	);

	mem_slot_writer mem_slot_writer_i (
		.clk_sys    (clk_sys),
		.reset_n    (reset_n),
		.io_cycle_i (io_cycle_i),
		.prg_req    (parse_req.consumer),
		.ptr_req    (patch_req.consumer),
		.mem_we_o   (mem_we_o),
		.mem_addr_o (mem_addr_o),
		.mem_data_o (mem_data_o)
	);

	autotype_keyseq #(
		.KEY_HOLD_CYCLES (KEY_HOLD_CYCLES)
	) autotype_keyseq_i (
		.clk_sys      (clk_sys),
		.reset_n      (reset_n),
		.patch_done_i (patch_done),
		.ps2_key_i    (ps2_key_i),
		.ps2_key_o    (ps2_key_o)
	);

endmodule

`default_nettype wire

//--- verification/prg_loader_tb.sv
/*
 * Random-stimulus testbench for the PRG injection path.
 * Streams PRG files through the download port while io_cycle_i blocks
 * RAM slots at random, records every RAM write in a 64K model and checks
 * the data, the BASIC pointer bytes and the autotyped RUN key sequence.
 */
`default_nettype none

module prg_loader_tb;

	localparam int HOLD        = 8;
	localparam int MAX_LEN     = 40;
	localparam int N_LOADS     = 2;
	localparam int N_PTR       = 12;
	localparam int N_KEYS      = 12;
	localparam int IO_MAX_HIGH = 48;
	localparam int WAIT_LIMIT  = 4000;
	localparam int LOAD_CYCLES = (MAX_LEN + 2 + N_PTR) * (IO_MAX_HIGH + 12) + N_KEYS * HOLD + 400;
	localparam int WATCHDOG_CYCLES = 3 * (N_LOADS * LOAD_CYCLES + 20);

	// Zero page pointers in patch order, TXT then SAVE_START then end address pairs
	localparam logic [7:0] PTR_ADDR [N_PTR] = '{8'h2B, 8'h2C, 8'hAC, 8'hAD, 8'h2D, 8'h2E,
		8'h2F, 8'h30, 8'h31, 8'h32, 8'hAE, 8'hAF};

	// PS/2 set 2: shift, HOME (E0), R, U, N, RETURN
	localparam logic [7:0] SEQ_CODE [N_KEYS] = '{8'h12, 8'h6C, 8'h6C, 8'h12, 8'h2D, 8'h2D,
		8'h3C, 8'h3C, 8'h31, 8'h31, 8'h5A, 8'h5A};
	localparam logic SEQ_PRESS [N_KEYS] = '{1, 1, 0, 0, 1, 0, 1, 0, 1, 0, 1, 0};
	localparam logic SEQ_EXT [N_KEYS]   = '{0, 1, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0};

	logic                  clk_sys;
	logic                  reset_n;
	logic                  dl_active_i;
	logic                  dl_wr_i;
	loader_pkg::ram_addr_t dl_addr_i;
	loader_pkg::ram_data_t dl_data_i;
	logic                  dl_wait_o;
	logic                  io_cycle_i;
	logic                  mem_we_o;
	loader_pkg::ram_addr_t mem_addr_o;
	loader_pkg::ram_data_t mem_data_o;
	loader_pkg::ps2_key_t  ps2_key_i;
	loader_pkg::ps2_key_t  ps2_key_o;

	// RAM model, write_load tells which download wrote each byte last
	loader_pkg::ram_data_t ram [65536];
	int                    write_load [65536];
	int                    write_count;
	int                    io_violations;
	int                    load_no;
	logic                  heavy;

	string test_name;
	int    errors;
	int    checks;
	int    test_errors_at;
	int    test_checks_at;

	prg_loader_top #(
		.KEY_HOLD_CYCLES (20'(HOLD))
	) prg_loader_top_i (
		.clk_sys     (clk_sys),
		.reset_n     (reset_n),
		.dl_active_i (dl_active_i),
		.dl_wr_i     (dl_wr_i),
		.dl_addr_i   (dl_addr_i),
		.dl_data_i   (dl_data_i),
		.dl_wait_o   (dl_wait_o),
		.io_cycle_i  (io_cycle_i),
		.mem_we_o    (mem_we_o),
		.mem_addr_o  (mem_addr_o),
		.mem_data_o  (mem_data_o),
		.ps2_key_i   (ps2_key_i),
		.ps2_key_o   (ps2_key_o)
	);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	// CPU bus activity, low phases of at least two cycles open the slots
	initial begin
		int hi;
		io_cycle_i = 1'b0;
		@(negedge clk_sys);
		forever begin
			repeat ($urandom_range(2, 4)) @(negedge clk_sys);
			io_cycle_i = 1'b1;
			if (heavy)
				hi = ($urandom_range(0, 3) == 0) ? $urandom_range(20, IO_MAX_HIGH) : $urandom_range(1, 6);
			else
				hi = $urandom_range(1, 3);
			repeat (hi) @(negedge clk_sys);
			io_cycle_i = 1'b0;
		end
	end

	always @(posedge clk_sys) begin
		if (reset_n && mem_we_o) begin
			ram[mem_addr_o]        = mem_data_o;
			write_load[mem_addr_o] = load_no;
			write_count++;
			if (io_cycle_i) begin
				$display("RAM write at %h while the CPU owned the bus in %s", mem_addr_o, test_name);
				io_violations++;
			end
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
		$display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
		$display("Something failed");
		$finish;
	end

	task automatic check_value(input string what, input int exp, input int act);
		checks++;
		assert (exp == act) else begin
			$display("Fail %s %s: expected %0h, actual %0h", test_name, what, exp, act);
			errors++;
		end
	endtask

	task automatic start_test(input string name);
		test_name      = name;
		test_errors_at = errors;
		test_checks_at = checks;
	endtask

	task automatic end_test();
		$display("Test %s done: %0d checks, %0d errors", test_name,
			checks - test_checks_at, errors - test_errors_at);
	endtask

	function automatic int ptr_expect(input int k, input int end_a);
		if (k == 0)
			return 'h01;
		if (k == 1)
			return 'h08;
		if (k < 4)
			return 0;
		if (k % 2 == 0)
			return end_a & 'hFF;
		return (end_a >> 8) & 'hFF;
	endfunction

	function automatic bit expected_addr(input int a, input int load_a, input int len);
		if (a >= load_a && a < load_a + len)
			return 1'b1;
		for (int k = 0; k < N_PTR; k++)
			if (a == int'(PTR_ADDR[k]))
				return 1'b1;
		return 1'b0;
	endfunction

	// Host side, sends header and data and honours dl_wait_o
	task automatic send_prg(input int load_a, input loader_pkg::ram_data_t data_q[$]);
		dl_active_i = 1'b1;
		for (int i = 0; i < data_q.size() + 2; i++) begin
			repeat ($urandom_range(0, 3)) @(negedge clk_sys);
			while (dl_wait_o)
				@(negedge clk_sys);
			dl_wr_i   = 1'b1;
			dl_addr_i = 16'(i);
			dl_data_i = (i == 0) ? 8'(load_a) : (i == 1) ? 8'(load_a >> 8) : data_q[i - 2];
			@(negedge clk_sys);
			dl_wr_i = 1'b0;
		end
		repeat ($urandom_range(0, 2)) @(negedge clk_sys);
		dl_active_i = 1'b0;
	endtask

	task automatic check_keys(input loader_pkg::ps2_key_t live);
		loader_pkg::ps2_key_t exp;
		loader_pkg::ps2_key_t cur;
		logic                 tog;
		int                   n;
		n = 0;
		while (ps2_key_o == live && n < WAIT_LIMIT) begin
			@(negedge clk_sys);
			n++;
		end
		checks++;
		assert (ps2_key_o != live) else begin
			$display("Autotype never started after the download in %s", test_name);
			errors++;
			return;
		end
		tog = live.toggle;
		for (int k = 0; k < N_KEYS; k++) begin
			tog = ~tog;
			exp = {tog, SEQ_PRESS[k], SEQ_EXT[k], SEQ_CODE[k]};
			check_value($sformatf("key event %0d", k), int'(exp), int'(ps2_key_o));
			cur = ps2_key_o;
			n   = 0;
			while (ps2_key_o == cur && n < WAIT_LIMIT) begin
				@(negedge clk_sys);
				n++;
			end
			check_value($sformatf("hold of key event %0d", k), HOLD, n);
		end
		check_value("passthrough after sequence", int'(live), int'(ps2_key_o));
	endtask

	task automatic run_load(input int n, input int load_a, input int len);
		loader_pkg::ram_data_t data_q[$];
		loader_pkg::ps2_key_t  live;
		int                    start_count;
		int                    start_viol;
		int                    end_a;
		int                    stray;
		int                    w;
		start_test(n == 1 ? "load" : "reload_backpressure");
		load_no     = n;
		live        = {1'(n), 1'b1, 1'b0, 8'h1C};
		ps2_key_i   = live;
		start_count = write_count;
		start_viol  = io_violations;
		end_a       = load_a + len;
		for (int i = 0; i < len; i++)
			data_q.push_back(8'($urandom));
		send_prg(load_a, data_q);
		check_keys(live);
		w = 0;
		while (write_count - start_count < len + N_PTR && w < WAIT_LIMIT) begin
			@(negedge clk_sys);
			w++;
		end
		// Leave room for any write that should not be there
		repeat (IO_MAX_HIGH + 8) @(negedge clk_sys);
		check_value("RAM write count", len + N_PTR, write_count - start_count);
		check_value("writes during io cycle", 0, io_violations - start_viol);
		for (int i = 0; i < len; i++)
			check_value($sformatf("data byte %0d", i), int'(data_q[i]), int'(ram[16'(load_a + i)]));
		for (int k = 0; k < N_PTR; k++)
			check_value($sformatf("pointer %h", PTR_ADDR[k]), ptr_expect(k, end_a),
				int'(ram[{8'h00, PTR_ADDR[k]}]));
		stray = 0;
		for (int a = 0; a < 65536; a++)
			if (write_load[16'(a)] == n && !expected_addr(a, load_a, len))
				stray++;
		check_value("stray writes", 0, stray);
		live.toggle = ~live.toggle;
		live.code   = 8'h23;
		ps2_key_i   = live;
		@(negedge clk_sys);
		check_value("live key passthrough", int'(live), int'(ps2_key_o));
		end_test();
	endtask

	initial begin
		int load_a;
		int len;
		int prev_a;
		int prev_len;
		void'($urandom(41729));
		reset_n     = 1'b0;
		dl_active_i = 1'b0;
		dl_wr_i     = 1'b0;
		dl_addr_i   = '0;
		dl_data_i   = '0;
		ps2_key_i   = '0;
		heavy       = 1'b0;
		load_no     = 0;
		errors      = 0;
		checks      = 0;
		repeat (2) @(negedge clk_sys);
		reset_n = 1'b1;

		start_test("reset");
		check_value("dl_wait_o", 0, int'(dl_wait_o));
		check_value("mem_we_o", 0, int'(mem_we_o));
		check_value("ps2_key_o", int'(ps2_key_i), int'(ps2_key_o));
		end_test();

		prev_a   = 0;
		prev_len = 0;
		for (int n = 1; n <= N_LOADS; n++) begin
			heavy = (n == 2);
			do begin
				load_a = $urandom_range('h0200, 'hF000);
				len    = $urandom_range(3, MAX_LEN);
			end while (load_a == prev_a || len == prev_len);
			run_load(n, load_a, len);
			prev_a   = load_a;
			prev_len = len;
		end

		$display("Summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- sources.f
src/loader_pkg.sv
src/mem_req_if.sv
src/prg_stream_parser.sv
src/basic_ptr_patcher.sv
src/mem_slot_writer.sv
src/autotype_keyseq.sv
src/prg_loader_top.sv
verification/prg_loader_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := prg_loader_tb
FILELIST  := sources.f
OBJ_DIR   := obj_dir
PASS_MSG  := Everything OK

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
